/* common/sbuf_cfg.svh */
`ifndef SBUF_CFG_SVH
`define SBUF_CFG_SVH

// Datapath and bank geometry.
`define SBUF_DATA_W 16
`define SBUF_ADDR_W 14
`define SBUF_DEPTH 64

// Sliding window: lanes per window, channels, columns.
`define SBUF_L_COUNT 4
`define SBUF_C_COUNT 3
`define SBUF_W_COUNT 5
`define SBUF_W_STEP 4 // Address stride per column.

// Holds every read in flight plus one.
`define SBUF_QUEUE_DEPTH 4

`endif

/* common/sbuf_pkg.sv */
`default_nettype none

`include "sbuf_cfg.svh"

package sbuf_pkg;

	typedef logic [`SBUF_DATA_W-1:0] feat_t;
	typedef logic [`SBUF_ADDR_W-1:0] addr_t;

	// Addressed bank 1 write from the pooling or element-wise engine.
	typedef struct packed {
		addr_t addr;
		feat_t pool;
		feat_t eltwise;
		logic eltwise_sel; // Picks the element-wise word.
	} bank1_wr_t;

	// One item of the output stream.
	typedef struct packed {
		feat_t feat0; // From bank 0.
		feat_t feat1; // From bank 1.
	} feat_pair_t;

endpackage

`default_nettype wire

/* design/feature_bank.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sbuf_cfg.svh"

module feature_bank (
	input wire logic clk,
	input wire logic i_wen,
	input wire sbuf_pkg::addr_t i_waddr,
	input wire sbuf_pkg::feat_t i_wdata,
	input wire sbuf_pkg::addr_t i_raddr,
	output sbuf_pkg::feat_t o_rdata
);

	localparam IDX_W = $clog2(`SBUF_DEPTH);

	sbuf_pkg::feat_t mem [`SBUF_DEPTH];
	sbuf_pkg::addr_t raddr_q;
	sbuf_pkg::feat_t rdata_q;
	sbuf_pkg::feat_t rdata_pipe;

	always_ff @(posedge clk) begin
		if (i_wen) begin
			mem[i_waddr[IDX_W-1:0]] <= i_wdata;
		end
	end

	// Address register, array read, output stage.
	always_ff @(posedge clk) begin
		raddr_q <= i_raddr;
		rdata_q <= mem[raddr_q[IDX_W-1:0]]; // Old data on a same-cycle write.
		rdata_pipe <= rdata_q;
	end

	assign o_rdata = rdata_pipe;

	a_waddr_range: assert property (@(posedge clk) i_wen |-> i_waddr < `SBUF_DEPTH);

endmodule

`default_nettype wire

/* design/scan_addr_gen.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sbuf_cfg.svh"

module scan_addr_gen (
	input wire logic clk,
	input wire logic i_reset,
	input wire logic i_start,
	input wire logic i_pair_taken,
	output sbuf_pkg::addr_t o_raddr,
	output logic o_issue,
	output logic o_busy,
	output logic o_last_issued
);

	localparam L_W = $clog2(`SBUF_L_COUNT);
	localparam C_W = $clog2(`SBUF_C_COUNT);
	localparam W_W = $clog2(`SBUF_W_COUNT);
	localparam CR_W = $clog2(`SBUF_QUEUE_DEPTH + 1);

	logic [L_W-1:0] l_cnt;
	logic [C_W-1:0] c_cnt;
	logic [W_W-1:0] w_cnt;
	logic [CR_W-1:0] credits;
	logic [CR_W-1:0] outstanding;
	logic running;
	logic all_issued;
	logic start_ok;
	logic l_last;
	logic c_last;
	logic final_step;

	assign start_ok = i_start && !o_busy;
	assign o_issue = (running || start_ok) && (credits != '0); // First read in the start cycle.

	assign l_last = l_cnt == L_W'(`SBUF_L_COUNT - 1);
	assign c_last = c_cnt == C_W'(`SBUF_C_COUNT - 1);
	assign final_step = l_last && c_last && (w_cnt == W_W'(`SBUF_W_COUNT - 1));

	assign o_raddr = sbuf_pkg::addr_t'(w_cnt) * sbuf_pkg::addr_t'(`SBUF_W_STEP)
		+ sbuf_pkg::addr_t'(c_cnt) + sbuf_pkg::addr_t'(l_cnt);

	// Pairs issued but not yet taken downstream.
	assign outstanding = CR_W'(`SBUF_QUEUE_DEPTH) - credits;
	assign o_last_issued = all_issued;

	// Lane fastest, then channel, then column.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			l_cnt <= '0;
			c_cnt <= '0;
			w_cnt <= '0;
		end else if (o_issue) begin
			if (final_step) begin
				l_cnt <= '0;
				c_cnt <= '0;
				w_cnt <= '0;
			end else if (l_last && c_last) begin
				l_cnt <= '0;
				c_cnt <= '0;
				w_cnt <= w_cnt + 1'b1;
			end else if (l_last) begin
				l_cnt <= '0;
				c_cnt <= c_cnt + 1'b1;
			end else begin
				l_cnt <= l_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			credits <= CR_W'(`SBUF_QUEUE_DEPTH);
		end else begin
			case ({o_issue, i_pair_taken})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			running <= 1'b0;
			all_issued <= 1'b0;
			o_busy <= 1'b0;
		end else begin
			if (start_ok) begin
				running <= 1'b1;
				o_busy <= 1'b1;
			end
			if (o_issue && final_step) begin
				running <= 1'b0;
				all_issued <= 1'b1;
			end
			// Scan ends as the final pair leaves.
			if (all_issued && i_pair_taken && outstanding == CR_W'(1)) begin
				all_issued <= 1'b0;
				o_busy <= 1'b0;
			end
		end
	end

	a_credit_max: assert property (@(posedge clk) disable iff (i_reset)
		credits <= CR_W'(`SBUF_QUEUE_DEPTH));
	a_raddr_range: assert property (@(posedge clk) disable iff (i_reset)
		o_issue |-> o_raddr < `SBUF_DEPTH);

endmodule

`default_nettype wire

/* design/pair_queue.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sbuf_cfg.svh"

module pair_queue (
	input wire logic clk,
	input wire logic i_reset,
	input wire logic i_push,
	input wire sbuf_pkg::feat_pair_t i_pair,
	output logic o_valid,
	output sbuf_pkg::feat_pair_t o_pair,
	input wire logic i_ready
);

	localparam DEPTH = `SBUF_QUEUE_DEPTH;
	localparam PTR_W = $clog2(DEPTH);
	localparam CNT_W = $clog2(DEPTH + 1);

	sbuf_pkg::feat_pair_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic pop;

	assign o_valid = count != '0;
	assign o_pair = mem[rd_ptr]; // Held until popped.
	assign pop = o_valid && i_ready;

	always_ff @(posedge clk) begin
		if (i_push) begin
			mem[wr_ptr] <= i_pair;
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (i_push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({i_push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (i_reset)
		i_push |-> count != CNT_W'(DEPTH));

endmodule

`default_nettype wire

/* stream_buffer/stream_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sbuf_cfg.svh"

module stream_buffer (
	input wire logic clk,
	input wire logic i_reset,
	input wire logic i_ddr_valid,
	input wire sbuf_pkg::feat_t i_ddr_data,
	output logic o_ddr_ready,
	input wire logic i_wr_valid,
	input wire sbuf_pkg::bank1_wr_t i_wr,
	input wire logic i_start,
	output logic o_feat_valid,
	output sbuf_pkg::feat_pair_t o_feat,
	input wire logic i_feat_ready,
	output logic o_done,
	output logic o_busy
);

	localparam RD_LAT = 3; // Bank read latency.

	sbuf_pkg::addr_t load_ptr;
	sbuf_pkg::addr_t scan_addr;
	sbuf_pkg::feat_t b1_wdata;
	sbuf_pkg::feat_t b0_rdata;
	sbuf_pkg::feat_t b1_rdata;
	sbuf_pkg::feat_pair_t rd_pair;
	logic ddr_fire;
	logic scan_issue;
	logic pair_taken;
	logic busy_q;
	logic [RD_LAT-1:0] rd_valid;

	assign o_ddr_ready = !o_busy;
	assign ddr_fire = i_ddr_valid && o_ddr_ready;

	// DDR words fill bank 0 in order.
	always_ff @(posedge clk) begin
		if (i_reset || o_done) begin
			load_ptr <= '0;
		end else if (ddr_fire) begin
			if (load_ptr == sbuf_pkg::addr_t'(`SBUF_DEPTH - 1)) begin
				load_ptr <= '0;
			end else begin
				load_ptr <= load_ptr + 1'b1;
			end
		end
	end

	assign b1_wdata = i_wr.eltwise_sel ? i_wr.eltwise : i_wr.pool;

	feature_bank bank0_i (
		.clk(clk),
		.i_wen(ddr_fire),
		.i_waddr(load_ptr),
		.i_wdata(i_ddr_data),
		.i_raddr(scan_addr),
		.o_rdata(b0_rdata)
	);

	feature_bank bank1_i (
		.clk(clk),
		.i_wen(i_wr_valid),
		.i_waddr(i_wr.addr),
		.i_wdata(b1_wdata),
		.i_raddr(scan_addr),
		.o_rdata(b1_rdata)
	);

	scan_addr_gen scan_addr_gen_i (
		.clk(clk),
		.i_reset(i_reset),
		.i_start(i_start),
		.i_pair_taken(pair_taken),
		.o_raddr(scan_addr),
		.o_issue(scan_issue),
		.o_busy(o_busy),
		.o_last_issued()
	);

	// Read-valid flag alongside the bank pipeline.
	always_ff @(posedge clk) begin
		if (i_reset) begin
			rd_valid <= '0;
		end else begin
			rd_valid <= {rd_valid[RD_LAT-2:0], scan_issue};
		end
	end

	assign rd_pair.feat0 = b0_rdata;
	assign rd_pair.feat1 = b1_rdata;

	pair_queue pair_queue_i (
		.clk(clk),
		.i_reset(i_reset),
		.i_push(rd_valid[RD_LAT-1]),
		.i_pair(rd_pair),
		.o_valid(o_feat_valid),
		.o_pair(o_feat),
		.i_ready(i_feat_ready)
	);

	assign pair_taken = o_feat_valid && i_feat_ready;

	always_ff @(posedge clk) begin
		if (i_reset) begin
			busy_q <= 1'b0;
		end else begin
			busy_q <= o_busy;
		end
	end

	assign o_done = busy_q && !o_busy; // Busy falls only at scan end.

	// Done leaves nothing behind in the read path.
	a_done_drained: assert property (@(posedge clk) disable iff (i_reset)
		o_done |-> !o_feat_valid && rd_valid == '0);

endmodule

`default_nettype wire

/* design/stream_buffer_top.sv */
`timescale 1ns/100ps
`default_nettype none

module stream_buffer_top (
	input wire logic clk,
	input wire logic i_reset,
	input wire logic i_ddr_valid,
	input wire sbuf_pkg::feat_t i_ddr_data,
	output logic o_ddr_ready,
	input wire logic i_wr_valid,
	input wire sbuf_pkg::bank1_wr_t i_wr,
	input wire logic i_start,
	output logic o_feat_valid,
	output sbuf_pkg::feat_pair_t o_feat,
	input wire logic i_feat_ready,
	output logic o_done,
	output logic o_busy
);

	stream_buffer stream_buffer_i (
		.clk(clk),
		.i_reset(i_reset),
		.i_ddr_valid(i_ddr_valid),
		.i_ddr_data(i_ddr_data),
		.o_ddr_ready(o_ddr_ready),
		.i_wr_valid(i_wr_valid),
		.i_wr(i_wr),
		.i_start(i_start),
		.o_feat_valid(o_feat_valid),
		.o_feat(o_feat),
		.i_feat_ready(i_feat_ready),
		.o_done(o_done),
		.o_busy(o_busy)
	);

endmodule

`default_nettype wire

/* tb/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD = 50 // 100 ns period.
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

endmodule

`default_nettype wire

/* tb/stream_buffer_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "sbuf_cfg.svh"

module stream_buffer_tb;

	localparam int DEPTH = `SBUF_DEPTH;
	localparam int SCAN_LEN = `SBUF_L_COUNT * `SBUF_C_COUNT * `SBUF_W_COUNT;
	localparam int WAIT_LIMIT = 2000; // Cycles per wait loop.

	logic clk;
	logic i_reset;
	logic i_ddr_valid;
	sbuf_pkg::feat_t i_ddr_data;
	logic o_ddr_ready;
	logic i_wr_valid;
	sbuf_pkg::bank1_wr_t i_wr;
	logic i_start;
	logic o_feat_valid;
	sbuf_pkg::feat_pair_t o_feat;
	logic i_feat_ready;
	logic o_done;
	logic o_busy;

	sbuf_pkg::feat_t bank0_model [DEPTH];
	sbuf_pkg::feat_t bank1_model [DEPTH];
	int load_ptr_model;
	logic [31:0] lfsr;
	int value_errors;
	int protocol_errors;
	int timeout_errors;

	tb_clock clock_i (.clk(clk));

	stream_buffer_top stream_buffer_top_i (.*);

	// Galois LFSR, taps 32 22 2 1.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// Inputs change 10 ns after the rising edge.
	task automatic tick();
		@(posedge clk);
		#10;
	endtask

	task automatic compare_value(input string test, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected) else begin
			value_errors++;
			$display("FAIL %s %s: expected %h, actual %h", test, what, expected, actual);
		end
	endtask

	task automatic expect_true(input string test, input logic cond, input string problem);
		assert (cond === 1'b1) else begin
			protocol_errors++;
			$display("%s: %s", test, problem);
		end
	endtask

	task automatic load_ddr(input string test);
		int accepted;
		int waited;
		logic valid;
		accepted = 0;
		waited = 0;
		while (accepted < DEPTH && waited < WAIT_LIMIT) begin
			valid = rand_bits(2) != 32'd0; // About one gap in four.
			i_ddr_valid = valid;
			i_ddr_data = sbuf_pkg::feat_t'(rand_bits(`SBUF_DATA_W));
			if (valid && o_ddr_ready) begin
				bank0_model[load_ptr_model] = i_ddr_data;
				load_ptr_model = (load_ptr_model + 1) % DEPTH;
				accepted++;
			end
			tick();
			waited++;
		end
		i_ddr_valid = 1'b0;
		assert (accepted == DEPTH) else begin
			timeout_errors++;
			$display("%s: timed out waiting for DDR ready", test);
		end
	endtask

	task automatic write_bank1(input int addr, input logic eltwise_sel);
		sbuf_pkg::bank1_wr_t wr;
		wr.addr = sbuf_pkg::addr_t'(addr);
		wr.pool = sbuf_pkg::feat_t'(rand_bits(`SBUF_DATA_W));
		wr.eltwise = sbuf_pkg::feat_t'(rand_bits(`SBUF_DATA_W));
		wr.eltwise_sel = eltwise_sel;
		i_wr_valid = 1'b1;
		i_wr = wr;
		bank1_model[addr] = eltwise_sel ? wr.eltwise : wr.pool;
		tick();
		i_wr_valid = 1'b0;
	endtask

	task automatic run_scan(input string test, input logic random_ready, input logic extra_start);
		sbuf_pkg::feat_pair_t expected [$];
		sbuf_pkg::feat_pair_t exp_pair;
		sbuf_pkg::feat_pair_t held_pair;
		logic ready;
		logic held;
		logic first_seen;
		logic second_sent;
		int taken;
		int cycle;
		int done_count;
		int addr;
		held = 1'b0;
		first_seen = 1'b0;
		second_sent = 1'b0;
		taken = 0;
		done_count = 0;
		held_pair = '0;
		// Lane fastest, then channel, then column.
		for (int w = 0; w < `SBUF_W_COUNT; w++) begin
			for (int c = 0; c < `SBUF_C_COUNT; c++) begin
				for (int l = 0; l < `SBUF_L_COUNT; l++) begin
					addr = w * `SBUF_W_STEP + c + l;
					exp_pair.feat0 = bank0_model[addr];
					exp_pair.feat1 = bank1_model[addr];
					expected.push_back(exp_pair);
				end
			end
		end
		expect_true(test, !o_busy && o_ddr_ready, "DUT busy before the scan started");
		i_start = 1'b1;
		tick();
		cycle = 1;
		if (extra_start) begin
			i_ddr_valid = 1'b1; // Offered word must wait out the scan.
			i_ddr_data = sbuf_pkg::feat_t'(rand_bits(`SBUF_DATA_W));
		end
		while (taken < SCAN_LEN && cycle < WAIT_LIMIT) begin
			expect_true(test, o_busy && !o_ddr_ready, "busy or DDR ready wrong during scan");
			if (o_done) done_count++;
			if (held) begin
				expect_true(test, o_feat_valid, "valid dropped before the pair was taken");
				compare_value(test, "held pair", held_pair, o_feat);
			end
			if (o_feat_valid && !first_seen) begin
				first_seen = 1'b1;
				compare_value(test, "first valid cycle", 32'd4, 32'(cycle));
			end
			ready = random_ready ? (rand_bits(1) != 32'd0) : 1'b1;
			i_feat_ready = ready;
			// Second start once every read is out, while busy is still high.
			i_start = extra_start && !second_sent && taken == SCAN_LEN - 2;
			if (i_start) begin
				second_sent = 1'b1;
			end
			if (o_feat_valid && ready) begin
				compare_value(test, $sformatf("pair %0d", taken), expected[taken], o_feat);
				taken++;
			end
			held = o_feat_valid && !ready;
			held_pair = o_feat;
			tick();
			cycle++;
		end
		i_ddr_valid = 1'b0;
		i_start = 1'b0;
		assert (taken == SCAN_LEN) else begin
			timeout_errors++;
			$display("%s: timed out with %0d of %0d pairs taken", test, taken, SCAN_LEN);
		end
		compare_value(test, "done after last pair", 32'd1, 32'(o_done));
		for (int i = 0; i < 8; i++) begin
			if (o_done) done_count++;
			expect_true(test, !o_feat_valid, "pair presented after the scan ended");
			expect_true(test, !o_busy && o_ddr_ready, "DUT still busy after the scan");
			tick();
		end
		compare_value(test, "done pulses", 32'd1, 32'(done_count));
		i_feat_ready = 1'b0;
		load_ptr_model = 0; // Load pointer clears at scan end.
	endtask

	initial begin
		lfsr = 32'h60fa77f7;
		value_errors = 0;
		protocol_errors = 0;
		timeout_errors = 0;
		load_ptr_model = 0;
		i_reset = 1'b1;
		i_ddr_valid = 1'b0;
		i_ddr_data = '0;
		i_wr_valid = 1'b0;
		i_wr = '0;
		i_start = 1'b0;
		i_feat_ready = 1'b0;
		repeat (4) begin
			tick();
		end
		i_reset = 1'b0;
		compare_value("reset", "o_feat_valid", 32'd0, 32'(o_feat_valid));
		compare_value("reset", "o_done", 32'd0, 32'(o_done));
		compare_value("reset", "o_busy", 32'd0, 32'(o_busy));
		compare_value("reset", "o_ddr_ready", 32'd1, 32'(o_ddr_ready));

		load_ddr("ddr_load");
		for (int a = 0; a < DEPTH; a++) begin
			write_bank1(a, 1'b0);
		end
		run_scan("scan_ready_high", 1'b0, 1'b0);

		for (int n = 0; n < 32; n++) begin
			write_bank1(int'(rand_bits($clog2(DEPTH))), rand_bits(1) != 32'd0);
		end
		run_scan("scan_eltwise", 1'b0, 1'b0);

		load_ddr("ddr_reload");
		run_scan("scan_backpressure", 1'b1, 1'b1);
		run_scan("scan_after_stall", 1'b0, 1'b0); // Bank 0 untouched by the held DDR word.

		$display("Errors: value %0d, protocol %0d, timeout %0d",
			value_errors, protocol_errors, timeout_errors);
		if (value_errors + protocol_errors + timeout_errors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+common
common/sbuf_pkg.sv
design/feature_bank.sv
design/scan_addr_gen.sv
design/pair_queue.sv
stream_buffer/stream_buffer.sv
design/stream_buffer_top.sv
tb/tb_clock.sv
tb/stream_buffer_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the stream buffer testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module stream_buffer_tb -o stream_buffer_sim
./obj_dir/stream_buffer_sim | tee sim.log
if grep -qx "Simulation PASSED" sim.log; then
	exit 0
fi
exit 1
